/* src.f */
hw/buffer_pkg.sv
hw/status_pkg.sv
hw/buf_bus_if.sv
hw/buffer_ram.sv
hw/buffer_arbiter.sv
hw/bulk_out_writer.sv
hw/bulk_in_reader.sv
hw/status_leds.sv
hw/bulk_loopback_top.sv
bench/bulk_loopback_tb.sv

/* Makefile */
TOP := bulk_loopback_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f src.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* bench/bulk_loopback_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module bulk_loopback_tb;

  localparam int NUM_BYTES = 2000;
  // Roughly four cycles per looped byte plus the fixed phases
  localparam int CYCLE_LIMIT = 20000;

  logic       usb_clock = 1'b0;
  logic       rst_n = 1'b0;
  logic       configured_i = 1'b0;
  logic       sof_i = 1'b0;
  logic       crc_err_i = 1'b0;
  logic       out_valid_i = 1'b0;
  logic       out_ready_o;
  logic       out_last_i = 1'b0;
  logic [7:0] out_data_i = 8'h00;
  logic       in_valid_o;
  logic       in_ready_i = 1'b0;
  logic       in_last_o;
  logic [7:0] in_data_o;
  logic [3:0] leds_o;

  integer seed = 32'h5dff5dc7;
  int     cycle_count = 0;
  int     accepted_count = 0;
  int     acc_seen = 0;
  logic   prev_in_valid = 1'b0;

  // Reference model state
  buffer_pkg::buf_word_t exp_q[$];
  buffer_pkg::buf_word_t got_word;
  buffer_pkg::buf_word_t sent_word;
  logic [7:0] sof_count = 8'h00;
  logic       sof_prev = 1'b0;
  logic       crc_seen = 1'b0;
  logic       activity_d = 1'b0;
  logic       configured_d = 1'b0;

  bulk_loopback_top DUT (.*);

  initial begin
    forever #4 usb_clock = ~usb_clock;
  end

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  // True about once in mask+1 draws
  function automatic logic rand_hit(input logic [31:0] mask);
    rand_hit = (next_rand() & mask) == 32'd0;
  endfunction

  function automatic logic [3:0] expected_leds();
    logic [3:0] leds;
    leds = 4'b0000;
    leds[status_pkg::LED_ACTIVITY]   = activity_d;
    leds[status_pkg::LED_CONFIGURED] = configured_d;
    leds[status_pkg::LED_CRC]        = crc_seen;
    // Bit 2 of the SOF count gated by bit 1 once an error was seen
    leds[status_pkg::LED_BLINK]      = sof_count[2] && (!crc_seen || sof_count[1]);
    expected_leds = leds;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_word(input string name, input buffer_pkg::buf_word_t expected,
                            input buffer_pkg::buf_word_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf(
          "ERROR at %0t: %s expected last=%0b data=%02h, got last=%0b data=%02h",
          $time, name, expected.last, expected.data, actual.last, actual.data));
    end
  endtask

  task automatic check_leds(input string name, input logic [3:0] expected,
                            input logic [3:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("ERROR at %0t: %s expected %04b, got %04b",
                                  $time, name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("ERROR at %0t: %s expected %0b, got %0b",
                                  $time, name, expected, actual));
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      stop_with_failure($sformatf("ERROR at %0t: %s expected %0d, got %0d",
                                  $time, name, expected, actual));
    end
  endtask

  task automatic next_cycle();
    @(negedge usb_clock);
    sof_i = rand_hit(32'd3);
  endtask

  // Holds an unaccepted byte or else offers a fresh one when asked
  task automatic offer_byte(input logic want);
    logic [31:0] r;
    if (!out_valid_i || accepted_count != acc_seen) begin
      r = next_rand();
      out_valid_i = want;
      out_data_i  = r[7:0];
      out_last_i  = r[10:8] == 3'd0;
    end
    acc_seen = accepted_count;
  endtask

  task automatic stream_bytes(input int count, input logic random_ready);
    int start;
    start = accepted_count;
    while (accepted_count - start < count) begin
      next_cycle();
      in_ready_i = random_ready && !rand_hit(32'd7);
      offer_byte(accepted_count - start < count && !rand_hit(32'd7));
    end
  endtask

  task automatic drain_in();
    in_ready_i = 1'b1;
    while (out_valid_i || exp_q.size() != 0) begin
      next_cycle();
      offer_byte(1'b0);
    end
  endtask

  // Samples just before each edge and then advances the model registers
  always @(posedge usb_clock) begin
    if (!rst_n) begin
      sof_count    = 8'h00;
      sof_prev     = 1'b0;
      crc_seen     = 1'b0;
      activity_d   = 1'b0;
      configured_d = 1'b0;
    end else begin
      check_leds("leds_o", expected_leds(), leds_o);
      got_word.last = in_last_o;
      got_word.data = in_data_o;
      if (in_valid_o && in_ready_i) begin
        if (exp_q.size() == 0) begin
          stop_with_failure("IN stream returned a byte that was never sent");
        end else begin
          check_word("in_last_o/in_data_o", exp_q.pop_front(), got_word);
        end
      end
      if (out_valid_i && out_ready_o) begin
        sent_word.last = out_last_i;
        sent_word.data = out_data_i;
        exp_q.push_back(sent_word);
        accepted_count++;
      end
      if (sof_i && !sof_prev) begin
        sof_count++;
      end
      sof_prev     = sof_i;
      crc_seen     = crc_seen | crc_err_i;
      activity_d   = in_valid_o;
      configured_d = configured_i;
    end
  end

  always @(posedge usb_clock) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      stop_with_failure($sformatf("Run did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  initial begin
    int start;
    repeat (10) @(negedge usb_clock);
    rst_n = 1'b1;
    next_cycle();
    check_bit("out_ready_o", 1'b0, out_ready_o);
    check_bit("in_valid_o", 1'b0, in_valid_o);
    check_leds("leds_o", 4'b0000, leds_o);
    configured_i = 1'b1;

    // Random loopback traffic
    stream_bytes(NUM_BYTES, 1'b1);
    drain_in();

    // IN stalled so sixteen memory words and the holding register fill up
    in_ready_i = 1'b0;
    start = accepted_count;
    for (int i = 0; i < 100; i++) begin
      next_cycle();
      if (i >= 60) begin
        check_bit("out_ready_o", 1'b0, out_ready_o);
      end
      offer_byte(1'b1);
    end
    check_count("bytes accepted with IN stalled", 17, accepted_count - start);
    drain_in();

    // While unconfigured the held IN word may leave but nothing new appears
    stream_bytes(5, 1'b0);
    repeat (4) next_cycle();
    configured_i = 1'b0;
    in_ready_i = 1'b1;
    prev_in_valid = in_valid_o;
    for (int i = 0; i < 40; i++) begin
      next_cycle();
      check_bit("out_ready_o", 1'b0, out_ready_o);
      if (in_valid_o && !prev_in_valid) begin
        stop_with_failure("in_valid_o rose while configured_i was low");
      end
      prev_in_valid = in_valid_o;
      offer_byte(1'b1);
    end
    configured_i = 1'b1;
    drain_in();

    // LED patterns with normal blink first and error blink later
    for (int i = 0; i < 400; i++) begin
      next_cycle();
      configured_i = !rand_hit(32'd3);
      crc_err_i = (i == 150) || (i > 150 && rand_hit(32'd31));
    end
    crc_err_i = 1'b0;
    configured_i = 1'b1;
    repeat (2) next_cycle();

    if (exp_q.size() != 0) begin
      stop_with_failure($sformatf("%0d sent bytes never came back on IN", exp_q.size()));
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* hw/bulk_loopback_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bulk_loopback_top (
  input  wire         usb_clock,
  input  wire         rst_n,
  input  wire         configured_i,
  input  wire         sof_i,
  input  wire         crc_err_i,
  // Bulk OUT stream from the host
  input  wire         out_valid_i,
  output logic        out_ready_o,
  input  wire         out_last_i,
  input  wire [7:0]   out_data_i,
  // Bulk IN stream back to the host
  output logic        in_valid_o,
  input  wire         in_ready_i,
  output logic        in_last_o,
  output logic [7:0]  in_data_o,
  output logic [3:0]  leds_o
);

  logic [buffer_pkg::BUF_PTR_W-1:0] wr_ptr;
  logic [buffer_pkg::BUF_PTR_W-1:0] rd_ptr;

  buf_bus_if wr_bus ();
  buf_bus_if rd_bus ();

  bulk_out_writer u_writer (
    .usb_clock    (usb_clock),
    .rst_n        (rst_n),
    .configured_i (configured_i),
    .out_valid_i  (out_valid_i),
    .out_ready_o  (out_ready_o),
    .out_last_i   (out_last_i),
    .out_data_i   (out_data_i),
    .rd_ptr_i     (rd_ptr),
    .wr_ptr_o     (wr_ptr),
    .bus          (wr_bus.requester)
  );

  bulk_in_reader u_reader (
    .usb_clock    (usb_clock),
    .rst_n        (rst_n),
    .configured_i (configured_i),
    .wr_ptr_i     (wr_ptr),
    .rd_ptr_o     (rd_ptr),
    .in_valid_o   (in_valid_o),
    .in_ready_i   (in_ready_i),
    .in_last_o    (in_last_o),
    .in_data_o    (in_data_o),
    .bus          (rd_bus.requester)
  );

  buffer_arbiter u_arbiter (
    .usb_clock (usb_clock),
    .rst_n     (rst_n),
    .wr_bus    (wr_bus.arbiter),
    .rd_bus    (rd_bus.arbiter)
  );

  // Activity LED follows IN data waiting
  status_leds u_status (
    .usb_clock    (usb_clock),
    .rst_n        (rst_n),
    .configured_i (configured_i),
    .sof_i        (sof_i),
    .crc_err_i    (crc_err_i),
    .activity_i   (in_valid_o),
    .leds_o       (leds_o)
  );

endmodule

`default_nettype wire

/* hw/status_leds.sv */
`timescale 1ns/1ps
`default_nettype none

module status_leds (
  input  wire         usb_clock,
  input  wire         rst_n,
  input  wire         configured_i,
  input  wire         sof_i,
  input  wire         crc_err_i,
  input  wire         activity_i,
  output logic [3:0]  leds_o
);

  logic                                  sof_q;
  logic [status_pkg::SOF_COUNT_W-1:0]    count_q;
  status_pkg::blink_mode_e               mode_q;
  logic                                  activity_q;
  logic                                  configured_q;
  logic                                  blink;

  always_ff @(posedge usb_clock or negedge rst_n) begin
    if (!rst_n) begin
      sof_q        <= 1'b0;
      count_q      <= '0;
      mode_q       <= status_pkg::BLINK_NORMAL;
      activity_q   <= 1'b0;
      configured_q <= 1'b0;
    end else begin
      sof_q        <= sof_i;
      activity_q   <= activity_i;
      configured_q <= configured_i;
      // Count rising edges only
      if (sof_i && !sof_q) begin
        count_q <= count_q + 1'b1;
      end
      // Sticky until reset
      if (crc_err_i) begin
        mode_q <= status_pkg::BLINK_ERROR;
      end
    end
  end

  // Error mode blinks in short bursts
  always_comb begin
    if (mode_q == status_pkg::BLINK_ERROR) begin
      blink = count_q[status_pkg::BLINK_BIT] && count_q[status_pkg::BLINK_ERR_BIT];
    end else begin
      blink = count_q[status_pkg::BLINK_BIT];
    end
  end

  always_comb begin
    leds_o                             = '0;
    leds_o[status_pkg::LED_ACTIVITY]   = activity_q;
    leds_o[status_pkg::LED_CONFIGURED] = configured_q;
    leds_o[status_pkg::LED_CRC]        = (mode_q == status_pkg::BLINK_ERROR);
    leds_o[status_pkg::LED_BLINK]      = blink;
  end

endmodule

`default_nettype wire

/* hw/bulk_in_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module bulk_in_reader (
  input  wire                                usb_clock,
  input  wire                                rst_n,
  input  wire                                configured_i,
  input  wire [buffer_pkg::BUF_PTR_W-1:0]    wr_ptr_i,
  output logic [buffer_pkg::BUF_PTR_W-1:0]   rd_ptr_o,
  output logic                               in_valid_o,
  input  wire                                in_ready_i,
  output logic                               in_last_o,
  output logic [7:0]                         in_data_o,
  buf_bus_if.requester                       bus
);

  localparam int PW = buffer_pkg::BUF_PTR_W;

  logic [PW-1:0]           fetch_ptr_q;
  logic [PW-1:0]           rd_ptr_q;
  logic                    pending_q;
  logic                    out_valid_q;
  buffer_pkg::buf_word_t   out_q;
  logic                    empty;

  assign empty = (wr_ptr_i == fetch_ptr_q);

  // One fetch at a time, only into a free output register
  assign bus.req   = !empty && configured_i && !pending_q && !out_valid_q;
  assign bus.we    = 1'b0;
  assign bus.addr  = fetch_ptr_q[buffer_pkg::BUF_ADDR_W-1:0];
  assign bus.wdata = '0;

  // The slot is released to the writer once the word leaves on IN
  always_ff @(posedge usb_clock or negedge rst_n) begin
    if (!rst_n) begin
      fetch_ptr_q <= '0;
      rd_ptr_q    <= '0;
      pending_q   <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      pending_q <= bus.req && bus.gnt;
      if (bus.req && bus.gnt) begin
        fetch_ptr_q <= fetch_ptr_q + 1'b1;
      end
      if (pending_q) begin
        out_valid_q <= 1'b1;
      end else if (out_valid_q && in_ready_i) begin
        out_valid_q <= 1'b0;
        rd_ptr_q    <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge usb_clock) begin
    if (pending_q) begin
      out_q <= bus.rdata;
    end
  end

  assign in_valid_o = out_valid_q;
  assign in_last_o  = out_q.last;
  assign in_data_o  = out_q.data;
  assign rd_ptr_o   = rd_ptr_q;

endmodule

`default_nettype wire

/* hw/bulk_out_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module bulk_out_writer (
  input  wire                                usb_clock,
  input  wire                                rst_n,
  input  wire                                configured_i,
  input  wire                                out_valid_i,
  output logic                               out_ready_o,
  input  wire                                out_last_i,
  input  wire [7:0]                          out_data_i,
  input  wire [buffer_pkg::BUF_PTR_W-1:0]    rd_ptr_i,
  output logic [buffer_pkg::BUF_PTR_W-1:0]   wr_ptr_o,
  buf_bus_if.requester                       bus
);

  localparam int AW = buffer_pkg::BUF_ADDR_W;
  localparam int PW = buffer_pkg::BUF_PTR_W;

  logic                    hold_valid_q;
  buffer_pkg::buf_word_t   hold_q;
  logic [PW-1:0]           wr_ptr_q;
  logic                    full;

  // Same slot, opposite lap
  assign full = (wr_ptr_q[AW-1:0] == rd_ptr_i[AW-1:0]) &&
                (wr_ptr_q[PW-1] != rd_ptr_i[PW-1]);

  assign out_ready_o = !hold_valid_q && configured_i;

  // Holding register feeds the write request
  assign bus.req   = hold_valid_q && !full;
  assign bus.we    = 1'b1;
  assign bus.addr  = wr_ptr_q[AW-1:0];
  assign bus.wdata = hold_q;

  always_ff @(posedge usb_clock or negedge rst_n) begin
    if (!rst_n) begin
      hold_valid_q <= 1'b0;
      wr_ptr_q     <= '0;
    end else if (bus.req && bus.gnt) begin
      hold_valid_q <= 1'b0;
      wr_ptr_q     <= wr_ptr_q + 1'b1;
    end else if (out_valid_i && out_ready_o) begin
      hold_valid_q <= 1'b1;
    end
  end

  // Payload, loaded on each accepted byte
  always_ff @(posedge usb_clock) begin
    if (out_valid_i && out_ready_o) begin
      hold_q.last <= out_last_i;
      hold_q.data <= out_data_i;
    end
  end

  assign wr_ptr_o = wr_ptr_q;

endmodule

`default_nettype wire

/* hw/buffer_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module buffer_arbiter (
  input  wire         usb_clock,
  input  wire         rst_n,
  buf_bus_if.arbiter  wr_bus,
  buf_bus_if.arbiter  rd_bus
);

  buffer_pkg::grant_e                  last_q;
  logic                                wr_win;
  logic                                rd_win;
  logic                                ram_en;
  logic                                ram_we;
  logic [buffer_pkg::BUF_ADDR_W-1:0]   ram_addr;
  buffer_pkg::buf_word_t               ram_wdata;
  buffer_pkg::buf_word_t               ram_rdata;

  // Writer wins a tie only if the reader had the last turn
  always_comb begin
    wr_win = wr_bus.req && (!rd_bus.req || last_q == buffer_pkg::GRANT_READ);
    rd_win = rd_bus.req && !wr_win;
  end

  assign wr_bus.gnt = wr_win;
  assign rd_bus.gnt = rd_win;

  // Steer the winner onto the memory port
  always_comb begin
    ram_en = wr_win || rd_win;
    if (wr_win) begin
      ram_we    = wr_bus.we;
      ram_addr  = wr_bus.addr;
      ram_wdata = wr_bus.wdata;
    end else begin
      ram_we    = rd_bus.we;
      ram_addr  = rd_bus.addr;
      ram_wdata = rd_bus.wdata;
    end
  end

  always_ff @(posedge usb_clock or negedge rst_n) begin
    if (!rst_n) begin
      last_q <= buffer_pkg::GRANT_READ;
    end else if (wr_win) begin
      last_q <= buffer_pkg::GRANT_WRITE;
    end else if (rd_win) begin
      last_q <= buffer_pkg::GRANT_READ;
    end
  end

  buffer_ram u_buffer_ram (
    .usb_clock (usb_clock),
    .en_i      (ram_en),
    .we_i      (ram_we),
    .addr_i    (ram_addr),
    .wdata_i   (ram_wdata),
    .rdata_o   (ram_rdata)
  );

  // Only a reader granted in the previous cycle looks at this
  assign wr_bus.rdata = ram_rdata;
  assign rd_bus.rdata = ram_rdata;

endmodule

`default_nettype wire

/* hw/buffer_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module buffer_ram (
  input  wire                                 usb_clock,
  input  wire                                 en_i,
  input  wire                                 we_i,
  input  wire [buffer_pkg::BUF_ADDR_W-1:0]    addr_i,
  input  wire buffer_pkg::buf_word_t          wdata_i,
  output buffer_pkg::buf_word_t               rdata_o
);

  buffer_pkg::buf_word_t mem [buffer_pkg::BUF_DEPTH];

  // Single port, read data registered for one cycle
  always_ff @(posedge usb_clock) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

/* hw/buf_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface buf_bus_if;

  // Request side
  logic                                req;
  logic                                we;
  logic [buffer_pkg::BUF_ADDR_W-1:0]   addr;
  buffer_pkg::buf_word_t               wdata;

  // Arbiter side, gnt is combinational from req
  logic                                gnt;
  buffer_pkg::buf_word_t               rdata;

  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    input  gnt,
    input  rdata
  );

  modport arbiter (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output gnt,
    output rdata
  );

endinterface

`default_nettype wire

/* hw/status_pkg.sv */
`default_nettype none

package status_pkg;

  // Start-of-frame counter
  localparam int SOF_COUNT_W = 8;

  // Counter taps for the blink LED
  localparam int BLINK_BIT = 2;
  localparam int BLINK_ERR_BIT = 1;

  // LED bit positions
  localparam int LED_ACTIVITY = 0;
  localparam int LED_CONFIGURED = 1;
  localparam int LED_CRC = 2;
  localparam int LED_BLINK = 3;

  // Blink pattern, error mode once a CRC error was seen
  typedef enum logic {
    BLINK_NORMAL = 1'b0,
    BLINK_ERROR  = 1'b1
  } blink_mode_e;

endpackage

`default_nettype wire

/* hw/buffer_pkg.sv */
`default_nettype none

package buffer_pkg;

  // Buffer geometry
  localparam int BUF_DEPTH = 16;
  localparam int BUF_ADDR_W = 4;

  // One extra wrap bit tells full from empty
  localparam int BUF_PTR_W = 5;

  // Stored stream word, last flag above the data byte
  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } buf_word_t;

  // Side that won the memory port last time
  typedef enum logic {
    GRANT_WRITE = 1'b0,
    GRANT_READ  = 1'b1
  } grant_e;

endpackage

`default_nettype wire
